// ==== all.f ====
verilog/dmaPkg.sv
verilog/blockBuffer.sv
verilog/axiReadMaster.sv
verilog/axiWriteMaster.sv
verilog/ringFetchCtrl.sv
verilog/ringDmaTop.sv
test/ringDmaChecker.sv
test/ringDmaTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ring DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module ringDmaTb -f all.f -o ringDmaSim \
   && ./obj_dir/ringDmaSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== test/ringDmaChecker.sv ====
`timescale 1ns/1ps

module ringDmaChecker (
   input  logic             clk,
   input  logic             rst_n,
   input  dmaPkg::addrT     araddr,
   input  logic             arvalid,
   input  logic             arready,
   input  dmaPkg::axiRBeatT rBeat,
   input  logic             rvalid,
   input  logic             rready,
   input  dmaPkg::addrT     awaddr,
   input  logic             awvalid,
   input  logic             awready,
   input  dmaPkg::dataT     wdata,
   input  logic             wvalid,
   input  logic             wready,
   input  logic [1:0]       bresp,
   input  logic             bvalid,
   input  logic             bready,
   input  logic             bufRdEn,
   input  dmaPkg::beatIdxT  bufRdAddr,
   input  dmaPkg::dataT     bufRdData,
   input  logic             blockReady,
   input  logic             blockTaken,
   output int               valueErrs,
   output int               otherErrs
);

   typedef enum logic [1:0] {
      WAIT_PTR,
      WAIT_BLK,
      WAIT_WR,
      WAIT_TAKE
   } phaseT;

   phaseT           phase;
   logic [3:0]      consSlot;
   logic [3:0]      nextSlot;
   dmaPkg::addrT    expAddr;
   dmaPkg::dataT    expBuf [dmaPkg::BLOCK_BEATS];
   int              beat;
   int              sinceRelease;
   logic            expReady;
   logic            bGoodLast;
   logic            rdPending;
   dmaPkg::beatIdxT rdIdx;

   task automatic mismatch(input string what, input logic [127:0] expVal,
                           input logic [127:0] actVal);
      valueErrs++;
      $display("FAIL %s: expected %0h, actual %0h", what, expVal, actVal);
   endtask

   task automatic problem(input string what);
      otherErrs++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         phase        = WAIT_PTR;
         consSlot     = '0;
         expAddr      = dmaPkg::PTR_ADDR;
         beat         = 0;
         sinceRelease = 0;
         expReady     = 1'b0;
         bGoodLast    = 1'b0;
         rdPending    = 1'b0;
      end else begin
         nextSlot = 4'((int'(consSlot) + 1) % dmaPkg::NUM_SLOTS);

         // Quiet bus until the first poll
         if (sinceRelease < dmaPkg::POLL_PERIOD) begin
            sinceRelease++;
            if (arvalid || rready || awvalid || wvalid || bready || blockReady) begin
               problem("a valid, ready or blockReady output is high before the first poll");
            end
         end

         if (blockReady !== expReady) begin
            mismatch("blockReady", 128'(expReady), 128'(blockReady));
         end
         if (blockTaken) begin
            expReady = 1'b0;
         end
         if (bGoodLast) begin
            expReady = 1'b1;
         end
         bGoodLast = 1'b0;
         if (blockReady && arvalid) begin
            problem("AR request raised while blockReady is high");
         end

         // Buffer read data lags the request by one cycle
         if (rdPending && bufRdData !== expBuf[rdIdx]) begin
            mismatch($sformatf("bufRdData[%0d]", rdIdx), expBuf[rdIdx], bufRdData);
         end
         rdPending = bufRdEn;
         rdIdx     = bufRdAddr;

         if (arvalid && arready) begin
            if (phase == WAIT_PTR || phase == WAIT_BLK) begin
               if (araddr !== expAddr) begin
                  mismatch("araddr", 128'(expAddr), 128'(araddr));
               end
            end else begin
               problem("AR handshake while no read was expected");
            end
         end

         if (rvalid && rready) begin
            case (phase)
               WAIT_PTR: begin
                  if (rBeat.rresp == dmaPkg::RESP_OKAY && rBeat.rdata[15:12] != consSlot) begin
                     phase   = WAIT_BLK;
                     beat    = 0;
                     expAddr = dmaPkg::addrT'(consSlot) * 64'd4096;
                  end
               end
               WAIT_BLK: begin
                  if (rBeat.rresp == dmaPkg::RESP_OKAY) begin
                     expBuf[beat] = rBeat.rdata;
                     if (beat == dmaPkg::BLOCK_BEATS - 1) begin
                        phase = WAIT_WR;
                     end else begin
                        beat++;
                        expAddr = dmaPkg::addrT'(consSlot) * 64'd4096
                                  + dmaPkg::addrT'(beat * dmaPkg::BEAT_BYTES);
                     end
                  end
               end
               default: problem("R beat accepted while no read was expected");
            endcase
         end

         if (awvalid && awready) begin
            if (phase != WAIT_WR) begin
               problem("AW handshake while no write-back was expected");
            end else if (awaddr !== dmaPkg::CONS_ADDR) begin
               mismatch("awaddr", 128'(dmaPkg::CONS_ADDR), 128'(awaddr));
            end
         end

         if (wvalid && wready) begin
            if (phase != WAIT_WR) begin
               problem("W handshake while no write-back was expected");
            end else if (wdata !== (dmaPkg::dataT'(nextSlot) << dmaPkg::SLOT_SHIFT)) begin
               mismatch("wdata", dmaPkg::dataT'(nextSlot) << dmaPkg::SLOT_SHIFT, wdata);
            end
         end

         if (bvalid && bready) begin
            if (phase != WAIT_WR) begin
               problem("B response accepted while no write-back was pending");
            end else if (bresp == dmaPkg::RESP_OKAY) begin
               consSlot  = nextSlot;
               phase     = WAIT_TAKE;
               bGoodLast = 1'b1;
            end
         end

         if (phase == WAIT_TAKE && blockTaken) begin
            phase   = WAIT_PTR;
            expAddr = dmaPkg::PTR_ADDR;
         end
      end
   end

endmodule

// ==== test/ringDmaTb.sv ====
`timescale 1ns/1ps

module ringDmaTb;

   logic             clk = 1'b0;
   logic             rst_n;
   dmaPkg::addrT     araddr;
   logic             arvalid;
   logic             arready;
   dmaPkg::axiRBeatT rBeat;
   logic             rvalid;
   logic             rready;
   dmaPkg::addrT     awaddr;
   logic             awvalid;
   logic             awready;
   dmaPkg::dataT     wdata;
   logic             wvalid;
   logic             wready;
   logic [1:0]       bresp;
   logic             bvalid;
   logic             bready;
   logic             bufRdEn;
   dmaPkg::beatIdxT  bufRdAddr;
   dmaPkg::dataT     bufRdData;
   logic             blockReady;
   logic             blockTaken;
   int               valueErrs;
   int               otherErrs;

   // Six words per line for kind, count, delay A, delay B, response and data
   logic [127:0]     stim [0:383];
   logic [31:0]      lfsr;
   int               cycles = 0;
   int               cycleLimit;

   always #50 clk = ~clk;

   ringDmaTop uut (.*);

   ringDmaChecker scoreboard (.*);

   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      // Taps 32, 22, 2, 1
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic drawDelay(input logic [3:0] field, output int d);
      d = 0;
      if (field == 4'hF) begin
         repeat (2) begin
            lfsr = lfsrNext(lfsr);
            d    = d * 2 + int'(lfsr[0]);
         end
      end else begin
         d = int'(field);
      end
   endtask

   task automatic serveRead(input int arDelay, input int rDelay, input logic [1:0] resp,
                            input dmaPkg::dataT data, input logic fill);
      dmaPkg::addrT addr;
      do @(posedge clk); while (!arvalid);
      repeat (arDelay) @(posedge clk);
      arready <= 1'b1;
      @(posedge clk);
      addr = araddr;
      arready <= 1'b0;
      repeat (rDelay) @(posedge clk);
      // Block payload is mixed with the full beat address
      rBeat.rdata <= fill ? (data ^ {addr, ~addr}) : data;
      rBeat.rresp <= resp;
      rvalid      <= 1'b1;
      do @(posedge clk); while (!rready);
      rvalid <= 1'b0;
   endtask

   task automatic serveWrite(input int awDelay, input int wDelay, input logic [1:0] resp);
      do @(posedge clk); while (!(awvalid && wvalid));
      fork
         begin
            repeat (awDelay) @(posedge clk);
            awready <= 1'b1;
            @(posedge clk);
            awready <= 1'b0;
         end
         begin
            repeat (wDelay) @(posedge clk);
            wready <= 1'b1;
            @(posedge clk);
            wready <= 1'b0;
         end
      join
      bresp  <= resp;
      bvalid <= 1'b1;
      do @(posedge clk); while (!bready);
      bvalid <= 1'b0;
   endtask

   task automatic drainBlock();
      int i;
      do @(posedge clk); while (!blockReady);
      for (i = 0; i < dmaPkg::BLOCK_BEATS; i++) begin
         bufRdEn   <= 1'b1;
         bufRdAddr <= dmaPkg::beatIdxT'(i);
         @(posedge clk);
      end
      bufRdEn <= 1'b0;
      @(posedge clk);
      blockTaken <= 1'b1;
      @(posedge clk);
      blockTaken <= 1'b0;
   endtask

   task automatic report(input logic aborted);
      $display("Summary: %0d value errors, %0d other errors%s", valueErrs, otherErrs,
               aborted ? ", run aborted" : "");
      if (!aborted && valueErrs == 0 && otherErrs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         report(1'b1);
         $finish;
      end
   end

   initial begin
      int numLines;
      int txCount;
      int base;
      int n;
      int dA;
      int dB;
      logic [3:0] kind;
      logic stimEmpty;
      rst_n      = 1'b0;
      arready    = 1'b0;
      rvalid     = 1'b0;
      rBeat      = '0;
      awready    = 1'b0;
      wready     = 1'b0;
      bresp      = 2'b00;
      bvalid     = 1'b0;
      bufRdEn    = 1'b0;
      bufRdAddr  = '0;
      blockTaken = 1'b0;
      lfsr       = 32'h719af856;
      $readmemh("test/ringDma_stim.txt", stim);
      numLines = 0;
      txCount  = 0;
      while (numLines < 64 && stim[numLines * 6][3:0] !== 4'hF) begin
         txCount += int'(stim[numLines * 6 + 1]);
         numLines++;
      end
      stimEmpty  = (numLines == 0);
      cycleLimit = 400 * txCount + 200;
      if (stimEmpty) begin
         $display("No stimulus lines were read from the stim file");
      end

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      for (int line = 0; line < numLines; line++) begin
         base = line * 6;
         kind = stim[base][3:0];
         for (n = 0; n < int'(stim[base + 1]); n++) begin
            drawDelay(stim[base + 2][3:0], dA);
            drawDelay(stim[base + 3][3:0], dB);
            if (kind == 4'h2) begin
               serveWrite(dA, dB, stim[base + 4][1:0]);
               if (stim[base + 4][1:0] == dmaPkg::RESP_OKAY) begin
                  drainBlock();
               end
            end else begin
               serveRead(dA, dB, stim[base + 4][1:0], stim[base + 5], kind == 4'h1);
            end
         end
      end

      repeat (40) @(posedge clk);
      report(stimEmpty);
      $finish;
   end

endmodule

// ==== test/ringDma_stim.txt ====
// kind count delayA delayB resp data; kind 0 pointer read, 1 block reads, 2 write-back, F end
// reads: arready and rvalid delays; writes: awready and wready delays; F draws 0..3 from the LFSR
0 1 0 0 0 0
0 1 2 1 0 1000
1 5 0 0 0 0123456789abcdef0f1e2d3c4b5a6978
1 1 1 2 2 0123456789abcdef0f1e2d3c4b5a6978
1 B F F 0 0123456789abcdef0f1e2d3c4b5a6978
2 1 2 0 2 0
2 1 0 3 0 0
0 1 0 0 2 1000
0 1 F F 0 4000
1 10 F F 0 fedcba9876543210a5a5a5a55a5a5a5a
2 1 1 1 0 0
0 1 1 0 0 4000
1 10 0 1 0 13579bdf02468ace1122334455667788
2 1 F F 0 0
0 1 0 2 0 4000
1 10 2 0 0 deadbeefcafef00d0badc0de8badf00d
2 1 3 0 0 0
0 1 0 1 0 4000
0 1 0 0 0 7000
1 10 F F 0 00ff00ff00ff00ff1234567812345678
2 1 0 2 1 0
2 1 F F 0 0
0 1 F F 0 7000
1 10 1 1 0 77777777888888889999999900000000
2 1 2 2 0 0
0 1 0 0 0 0
1 10 F F 0 31415926535897932384626433832795
2 1 0 0 0 0
0 1 2 2 0 1000
1 7 0 0 0 2718281828459045235360287471352f
1 1 F F 3 2718281828459045235360287471352f
1 9 F F 0 2718281828459045235360287471352f
2 1 F F 0 0
0 1 0 0 0 0
F 0 0 0 0 0

// ==== verilog/axiReadMaster.sv ====
`timescale 1ns/1ps

module axiReadMaster (
   input  logic             clk,
   input  logic             rst_n,

   input  dmaPkg::memReqT   req,
   output dmaPkg::memRspT   rsp,

   output dmaPkg::addrT     araddr,
   output logic             arvalid,
   input  logic             arready,

   input  dmaPkg::axiRBeatT rBeat,
   input  logic             rvalid,
   output logic             rready
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA
   } stateT;

   stateT        state;
   dmaPkg::addrT addrQ;
   dmaPkg::dataT dataQ;
   logic         doneQ;
   logic         errQ;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         doneQ <= 1'b0;
         errQ  <= 1'b0;
      end else begin
         doneQ <= 1'b0;
         case (state)
            IDLE: begin
               if (req.strobe) begin
                  state <= ADDR;
               end
            end
            ADDR: begin
               if (arready) begin
                  state <= DATA;
               end
            end
            DATA: begin
               if (rvalid) begin
                  state <= IDLE;
                  doneQ <= 1'b1;
                  errQ  <= (rBeat.rresp != dmaPkg::RESP_OKAY);
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Address and returned beat
   always_ff @(posedge clk) begin
      if (state == IDLE && req.strobe) begin
         addrQ <= req.addr;
      end
      if (state == DATA && rvalid) begin
         dataQ <= rBeat.rdata;
      end
   end

   assign araddr  = addrQ;
   assign arvalid = (state == ADDR);
   assign rready  = (state == DATA);

   assign rsp = '{done: doneQ, err: errQ, data: dataQ};

endmodule

// ==== verilog/axiWriteMaster.sv ====
`timescale 1ns/1ps

module axiWriteMaster (
   input  logic           clk,
   input  logic           rst_n,

   input  dmaPkg::memReqT req,
   output dmaPkg::memRspT rsp,

   output dmaPkg::addrT   awaddr,
   output logic           awvalid,
   input  logic           awready,

   output dmaPkg::dataT   wdata,
   output logic           wvalid,
   input  logic           wready,

   input  logic [1:0]     bresp,
   input  logic           bvalid,
   output logic           bready
);

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      RESP
   } stateT;

   stateT        state;
   dmaPkg::addrT addrQ;
   dmaPkg::dataT dataQ;
   logic         awDone;
   logic         wDone;
   logic         awAcc;
   logic         wAcc;
   logic         doneQ;
   logic         errQ;

   // Accepted earlier or in this cycle
   assign awAcc = awDone | (awvalid & awready);
   assign wAcc  = wDone | (wvalid & wready);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= IDLE;
         awDone <= 1'b0;
         wDone  <= 1'b0;
         doneQ  <= 1'b0;
         errQ   <= 1'b0;
      end else begin
         doneQ <= 1'b0;
         case (state)
            IDLE: begin
               if (req.strobe) begin
                  state  <= BUSY;
                  awDone <= 1'b0;
                  wDone  <= 1'b0;
               end
            end
            BUSY: begin
               awDone <= awAcc;
               wDone  <= wAcc;
               // AW and W may finish in either order
               if (awAcc && wAcc) begin
                  state <= RESP;
               end
            end
            RESP: begin
               if (bvalid) begin
                  state <= IDLE;
                  doneQ <= 1'b1;
                  errQ  <= (bresp != dmaPkg::RESP_OKAY);
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && req.strobe) begin
         addrQ <= req.addr;
         dataQ <= req.data;
      end
   end

   assign awaddr  = addrQ;
   assign wdata   = dataQ;
   assign awvalid = (state == BUSY) && !awDone;
   assign wvalid  = (state == BUSY) && !wDone;
   assign bready  = (state == RESP);

   // No read data on the write side
   assign rsp = '{done: doneQ, err: errQ, data: '0};

endmodule

// ==== verilog/blockBuffer.sv ====
`timescale 1ns/1ps

module blockBuffer (
   input  logic             clk,
   input  logic             rst_n,
   input  dmaPkg::bufWriteT wr,
   input  logic             rdEn,
   input  dmaPkg::beatIdxT  rdAddr,
   output dmaPkg::dataT     rdData
);

   dmaPkg::dataT mem [dmaPkg::BLOCK_BEATS];

   always_ff @(posedge clk) begin
      if (wr.we) begin
         mem[wr.idx] <= wr.data;
      end
   end

   // Read data one cycle after rdEn
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdData <= '0;
      end else if (rdEn) begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

// ==== verilog/dmaPkg.sv ====
package dmaPkg;

   // AXI bus geometry
   localparam int ADDR_W = 64;
   localparam int DATA_W = 128;

   // Poll counter runs 0 .. POLL_PERIOD-1
   localparam int POLL_PERIOD = 33;
   localparam int POLL_W      = $clog2(POLL_PERIOD);

   // Host memory layout of the ring
   localparam logic [ADDR_W-1:0] PTR_ADDR  = 64'h10;
   localparam logic [ADDR_W-1:0] CONS_ADDR = 64'h00;
   localparam int SLOT_SHIFT  = 12;
   localparam int NUM_SLOTS   = 8;
   localparam int BLOCK_BEATS = 16;
   localparam int BEAT_BYTES  = 16;
   localparam int BEAT_IDX_W  = $clog2(BLOCK_BEATS);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef logic [ADDR_W-1:0]     addrT;
   typedef logic [DATA_W-1:0]     dataT;
   typedef logic [3:0]            slotT;
   typedef logic [BEAT_IDX_W-1:0] beatIdxT;
   typedef logic [POLL_W-1:0]     pollCntT;

   // Pointer word: slot number in bits 15:12, everything else zero
   typedef struct packed {
      logic [111:0] rsvdHi;
      slotT         slot;
      logic [11:0]  rsvdLo;
   } ptrWordT;

   // A read beat is either a pointer word or block payload
   typedef union packed {
      dataT    raw;
      ptrWordT ptr;
   } ringWordT;

   typedef struct packed {
      logic strobe;
      addrT addr;
      dataT data;
   } memReqT;

   typedef struct packed {
      logic done;
      logic err;
      dataT data;
   } memRspT;

   typedef struct packed {
      dataT       rdata;
      logic [1:0] rresp;
   } axiRBeatT;

   typedef struct packed {
      logic    we;
      beatIdxT idx;
      dataT    data;
   } bufWriteT;

endpackage

// ==== verilog/ringDmaTop.sv ====
`timescale 1ns/1ps

module ringDmaTop (
   input  logic             clk,
   input  logic             rst_n,

   output dmaPkg::addrT     araddr,
   output logic             arvalid,
   input  logic             arready,
   input  dmaPkg::axiRBeatT rBeat,
   input  logic             rvalid,
   output logic             rready,

   output dmaPkg::addrT     awaddr,
   output logic             awvalid,
   input  logic             awready,
   output dmaPkg::dataT     wdata,
   output logic             wvalid,
   input  logic             wready,
   input  logic [1:0]       bresp,
   input  logic             bvalid,
   output logic             bready,

   input  logic             bufRdEn,
   input  dmaPkg::beatIdxT  bufRdAddr,
   output dmaPkg::dataT     bufRdData,
   output logic             blockReady,
   input  logic             blockTaken
);

   dmaPkg::memReqT rdReq;
   dmaPkg::memRspT rdRsp;
   dmaPkg::memReqT wrReq;
   dmaPkg::memRspT wrRsp;

   axiReadMaster rdMaster (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (rdReq),
      .rsp     (rdRsp),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rBeat   (rBeat),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   axiWriteMaster wrMaster (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (wrReq),
      .rsp     (wrRsp),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready)
   );

   ringFetchCtrl ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .rdReq      (rdReq),
      .rdRsp      (rdRsp),
      .wrReq      (wrReq),
      .wrRsp      (wrRsp),
      .bufRdEn    (bufRdEn),
      .bufRdAddr  (bufRdAddr),
      .bufRdData  (bufRdData),
      .blockReady (blockReady),
      .blockTaken (blockTaken)
   );

endmodule

// ==== verilog/ringFetchCtrl.sv ====
`timescale 1ns/1ps

module ringFetchCtrl (
   input  logic            clk,
   input  logic            rst_n,

   output dmaPkg::memReqT  rdReq,
   input  dmaPkg::memRspT  rdRsp,
   output dmaPkg::memReqT  wrReq,
   input  dmaPkg::memRspT  wrRsp,

   input  logic            bufRdEn,
   input  dmaPkg::beatIdxT bufRdAddr,
   output dmaPkg::dataT    bufRdData,

   output logic            blockReady,
   input  logic            blockTaken
);

   typedef enum logic [2:0] {
      IDLE,
      PTR_RD,
      BLK_RD,
      PTR_WR,
      HOLD
   } stateT;

   stateT            state;
   stateT            stateNext;
   dmaPkg::pollCntT  pollCnt;
   dmaPkg::slotT     consSlot;
   dmaPkg::slotT     nextSlot;
   dmaPkg::beatIdxT  beatIdx;
   dmaPkg::beatIdxT  beatIdxNext;
   dmaPkg::addrT     rdAddr;
   dmaPkg::addrT     rdAddrNext;
   logic             rdStrobe;
   logic             rdStrobeNext;
   logic             wrStrobe;
   logic             wrStrobeNext;
   logic             blockReadyNext;
   logic             consAdvance;
   dmaPkg::ringWordT ptrIn;
   dmaPkg::ringWordT ptrOut;
   dmaPkg::bufWriteT bufWr;

   // Free running poll timer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pollCnt <= '0;
      end else if (pollCnt == dmaPkg::pollCntT'(dmaPkg::POLL_PERIOD - 1)) begin
         pollCnt <= '0;
      end else begin
         pollCnt <= pollCnt + 1'b1;
      end
   end

   assign nextSlot = (consSlot == dmaPkg::slotT'(dmaPkg::NUM_SLOTS - 1)) ?
                     '0 : consSlot + 1'b1;

   assign ptrIn = rdRsp.data;

   always_comb begin
      ptrOut          = '0;
      ptrOut.ptr.slot = nextSlot;
   end

   always_comb begin
      stateNext      = state;
      beatIdxNext    = beatIdx;
      rdAddrNext     = rdAddr;
      rdStrobeNext   = 1'b0;
      wrStrobeNext   = 1'b0;
      blockReadyNext = blockReady;
      consAdvance    = 1'b0;
      case (state)
         IDLE: begin
            if (pollCnt == dmaPkg::pollCntT'(dmaPkg::POLL_PERIOD - 1)) begin
               stateNext    = PTR_RD;
               rdStrobeNext = 1'b1;
               rdAddrNext   = dmaPkg::PTR_ADDR;
            end
         end
         PTR_RD: begin
            if (rdRsp.done) begin
               if (rdRsp.err) begin
                  rdStrobeNext = 1'b1;
               end else if (ptrIn.ptr.slot == consSlot) begin
                  stateNext = IDLE;
               end else begin
                  stateNext    = BLK_RD;
                  beatIdxNext  = '0;
                  rdStrobeNext = 1'b1;
                  rdAddrNext   = dmaPkg::addrT'(consSlot) << dmaPkg::SLOT_SHIFT;
               end
            end
         end
         BLK_RD: begin
            if (rdRsp.done) begin
               if (rdRsp.err) begin
                  rdStrobeNext = 1'b1;
               end else if (beatIdx == dmaPkg::beatIdxT'(dmaPkg::BLOCK_BEATS - 1)) begin
                  stateNext    = PTR_WR;
                  wrStrobeNext = 1'b1;
               end else begin
                  beatIdxNext  = beatIdx + 1'b1;
                  rdStrobeNext = 1'b1;
                  rdAddrNext   = rdAddr + dmaPkg::addrT'(dmaPkg::BEAT_BYTES);
               end
            end
         end
         PTR_WR: begin
            if (wrRsp.done) begin
               if (wrRsp.err) begin
                  wrStrobeNext = 1'b1;
               end else begin
                  stateNext      = HOLD;
                  consAdvance    = 1'b1;
                  blockReadyNext = 1'b1;
               end
            end
         end
         HOLD: begin
            // Block stays owned downstream until taken
            if (blockTaken) begin
               stateNext      = IDLE;
               blockReadyNext = 1'b0;
            end
         end
         default: stateNext = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         consSlot   <= '0;
         beatIdx    <= '0;
         rdAddr     <= '0;
         rdStrobe   <= 1'b0;
         wrStrobe   <= 1'b0;
         blockReady <= 1'b0;
      end else begin
         state      <= stateNext;
         beatIdx    <= beatIdxNext;
         rdAddr     <= rdAddrNext;
         rdStrobe   <= rdStrobeNext;
         wrStrobe   <= wrStrobeNext;
         blockReady <= blockReadyNext;
         if (consAdvance) begin
            consSlot <= nextSlot;
         end
      end
   end

   assign rdReq = '{strobe: rdStrobe, addr: rdAddr, data: '0};
   assign wrReq = '{strobe: wrStrobe, addr: dmaPkg::CONS_ADDR, data: ptrOut.raw};

   // Good payload beats go straight into the buffer
   assign bufWr = '{we: (state == BLK_RD) && rdRsp.done && !rdRsp.err,
                    idx: beatIdx,
                    data: ptrIn.raw};

   blockBuffer buffer (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (bufWr),
      .rdEn   (bufRdEn),
      .rdAddr (bufRdAddr),
      .rdData (bufRdData)
   );

endmodule
